// ==== ccc_ctrl_pkg.sv ====
// CCC controller package with the sequencer state encoding and GET counter width
`default_nettype none

package ccc_ctrl_pkg;

  typedef enum logic [3:0] {
    Idle,
    WaitCcc,
    RxTbit,
    RxByte,
    RxByteTbit,
    RxDirectAddr,
    TxAddrAck,
    RxData,
    RxDataTbit,
    TxData,
    TxDataTbit,
    WaitBusCond,
    NextCcc,
    DoneCcc
  } ccc_state_e;

  // Longest GET response is GETPID with 6 bytes
  parameter int unsigned GetIdxW = 3;

endpackage

`default_nettype wire

// ==== ccc_fsm.sv ====
// CCC transfer sequencer covering T-bits, direct address, ACK and data phases
`default_nettype none

module ccc_fsm (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  i3c_ccc_pkg::ccc_code_e        ccc_i,
  input  logic                          ccc_valid_i,
  input  logic                          bus_rstart_det_i,
  input  logic                          bus_stop_det_i,
  input  logic [7:0]                    bus_rx_data_i,
  input  logic                          bus_rx_done_i,
  input  logic                          bus_tx_done_i,
  input  logic [i3c_ccc_pkg::AddrW-1:0] target_dyn_address_i,
  input  logic                          target_dyn_address_valid_i,
  output logic                          bus_rx_req_bit_o,
  output logic                          bus_rx_req_byte_o,
  output logic                          bus_tx_req_bit_o,
  output logic                          bus_tx_req_byte_o,
  output logic [7:0]                    bus_tx_req_value_o,
  output logic                          bus_tx_sel_od_pp_o,
  output logic                          done_fsm_o,
  output logic                          next_ccc_o,
  ccc_wr_if.wr                          wr,
  ccc_rd_if.ctrl                        rd
);
  import i3c_ccc_pkg::*;
  import ccc_ctrl_pkg::*;

  ccc_state_e       state_q, state_d;
  ccc_code_e        code_q;
  logic [AddrW-1:0] addr_q;
  logic             rnw_q;
  logic [7:0]       rx_byte_q;
  logic [2:0]       byte_idx_q;
  logic             last_q;
  logic             addr_rsvd;
  logic             addr_ack;

  assign addr_rsvd = (addr_q == RsvdAddr);
  // Our address ACKs only codes we can serve in the requested direction
  assign addr_ack = addr_rsvd |
                    (target_dyn_address_valid_i && (addr_q == target_dyn_address_i) &&
                     (rnw_q ? rd.supported : direct_code_supported(code_q)));

  assign wr.code           = code_q;
  assign wr.byte_data      = rx_byte_q;
  assign wr.byte_idx       = byte_idx_q;
  assign wr.byte_strobe    = (state_q == RxDataTbit) && bus_rx_done_i;
  assign wr.no_data_strobe = (state_q == RxTbit) && bus_rx_done_i && !is_direct_code(code_q);

  assign rd.code    = code_q;
  assign rd.load    = (state_q == TxAddrAck);
  assign rd.advance = (state_q == TxData) && bus_tx_done_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= WaitCcc;
      code_q     <= CccBcastEnec;
      byte_idx_q <= '0;
      last_q     <= 1'b0;
    end else begin
      // STOP ends the CCC from any state
      state_q <= bus_stop_det_i ? DoneCcc : state_d;
      if (state_q == WaitCcc && ccc_valid_i) begin
        code_q <= ccc_i;
      end
      if ((state_q == WaitCcc && ccc_valid_i) || (state_q == RxDirectAddr && bus_rx_done_i)) begin
        byte_idx_q <= '0;
      end else if (wr.byte_strobe && byte_idx_q != '1) begin
        byte_idx_q <= byte_idx_q + 3'd1;
      end
      // Keep last of the byte just sent for its T-bit
      if (rd.advance) begin
        last_q <= rd.last;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == RxDirectAddr && bus_rx_done_i) begin
      addr_q <= bus_rx_data_i[7:1];
      rnw_q  <= bus_rx_data_i[0];
    end
    if (state_q == RxData && bus_rx_done_i) begin
      rx_byte_q <= bus_rx_data_i;
    end
  end

  always_comb begin
    state_d            = state_q;
    bus_rx_req_bit_o   = 1'b0;
    bus_rx_req_byte_o  = 1'b0;
    bus_tx_req_bit_o   = 1'b0;
    bus_tx_req_byte_o  = 1'b0;
    bus_tx_req_value_o = 8'h00;
    bus_tx_sel_od_pp_o = 1'b0;
    done_fsm_o         = 1'b0;
    next_ccc_o         = 1'b0;
    case (state_q)
      WaitCcc: begin
        if (ccc_valid_i) state_d = RxTbit;
      end
      RxTbit: begin
        bus_rx_req_bit_o = 1'b1;
        if (bus_rx_done_i) state_d = is_direct_code(code_q) ? RxByte : RxData;
      end
      RxByte: begin
        bus_rx_req_byte_o = 1'b1;
        if (bus_rstart_det_i) state_d = RxDirectAddr;
        else if (bus_rx_done_i) state_d = RxByteTbit;
      end
      RxByteTbit: begin
        bus_rx_req_bit_o = 1'b1;
        if (bus_rx_done_i) state_d = RxByte;
      end
      RxDirectAddr: begin
        bus_rx_req_byte_o = 1'b1;
        if (bus_rx_done_i) state_d = TxAddrAck;
      end
      TxAddrAck: begin
        // ACK drives the line low and NACK leaves it high
        bus_tx_req_bit_o   = 1'b1;
        bus_tx_req_value_o = {7'h00, ~addr_ack};
        if (bus_tx_done_i) begin
          if (addr_rsvd) state_d = NextCcc;
          else if (!addr_ack) state_d = WaitBusCond;
          else if (rnw_q) state_d = TxData;
          else state_d = RxData;
        end
      end
      RxData: begin
        bus_rx_req_byte_o = 1'b1;
        if (bus_rstart_det_i) state_d = RxDirectAddr;
        else if (bus_rx_done_i) state_d = RxDataTbit;
      end
      RxDataTbit: begin
        bus_rx_req_bit_o = 1'b1;
        if (bus_rx_done_i) state_d = RxData;
      end
      TxData: begin
        bus_tx_req_byte_o  = 1'b1;
        bus_tx_req_value_o = rd.byte_data;
        bus_tx_sel_od_pp_o = 1'b1;
        if (bus_rstart_det_i) state_d = RxDirectAddr;
        else if (bus_tx_done_i) state_d = TxDataTbit;
      end
      TxDataTbit: begin
        // T-bit of 0 tells the controller the read is over
        bus_tx_req_bit_o   = 1'b1;
        bus_tx_req_value_o = {7'h00, ~last_q};
        bus_tx_sel_od_pp_o = 1'b1;
        if (bus_rstart_det_i) state_d = RxDirectAddr;
        else if (bus_tx_done_i) state_d = last_q ? WaitBusCond : TxData;
      end
      WaitBusCond: begin
        if (bus_rstart_det_i) state_d = RxDirectAddr;
      end
      NextCcc: begin
        next_ccc_o = 1'b1;
        state_d    = WaitCcc;
      end
      DoneCcc: begin
        done_fsm_o = 1'b1;
        state_d    = WaitCcc;
      end
      default: state_d = WaitCcc;
    endcase
  end

endmodule

`default_nettype wire

// ==== ccc_get_seq.sv ====
// GET response sequencer that serves CSR bytes most significant first
`default_nettype none

module ccc_get_seq #(
  parameter logic [7:0] IbiMaxPayload = 8'hFF
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic [7:0]                   get_bcr_i,
  input  logic [7:0]                   get_dcr_i,
  input  logic [15:0]                  get_mwl_i,
  input  logic [15:0]                  get_mrl_i,
  input  logic [15:0]                  get_status_i,
  input  logic [i3c_ccc_pkg::PidW-1:0] get_pid_i,
  ccc_rd_if.seq                        rd
);
  import i3c_ccc_pkg::*;
  import ccc_ctrl_pkg::*;

  // Bytes still to send including the current one
  logic [GetIdxW-1:0] cnt_q;
  logic [GetIdxW-1:0] len;
  logic [GetIdxW-1:0] pid_idx;

  always_comb begin
    case (rd.code)
      CccDirGetbcr, CccDirGetdcr:    len = 3'd1;
      CccDirGetmwl, CccDirGetstatus: len = 3'd2;
      CccDirGetmrl:                  len = 3'd3;
      CccDirGetpid:                  len = 3'd6;
      default:                       len = 3'd0;
    endcase
  end

  assign rd.supported = (len != '0);
  assign rd.last      = (cnt_q == 3'd1);
  assign pid_idx      = cnt_q - 3'd1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (rd.load) begin
      cnt_q <= len;
    end else if (rd.advance && cnt_q != '0) begin
      cnt_q <= cnt_q - 3'd1;
    end
  end

  always_comb begin
    rd.byte_data = 8'h00;
    case (rd.code)
      CccDirGetbcr:    rd.byte_data = get_bcr_i;
      CccDirGetdcr:    rd.byte_data = get_dcr_i;
      CccDirGetmwl:    rd.byte_data = (cnt_q == 3'd2) ? get_mwl_i[15:8] : get_mwl_i[7:0];
      CccDirGetstatus: rd.byte_data = (cnt_q == 3'd2) ? get_status_i[15:8] : get_status_i[7:0];
      CccDirGetmrl: begin
        if (cnt_q == 3'd3) rd.byte_data = get_mrl_i[15:8];
        else if (cnt_q == 3'd2) rd.byte_data = get_mrl_i[7:0];
        else rd.byte_data = IbiMaxPayload;
      end
      CccDirGetpid: begin
        if (cnt_q != '0) rd.byte_data = get_pid_i[8*pid_idx +: 8];
      end
      default: rd.byte_data = 8'h00;
    endcase
  end

endmodule

`default_nettype wire

// ==== ccc_rd_if.sv ====
// CCC read path through which the FSM steps the GET response sequencer
`default_nettype none

interface ccc_rd_if;
  import i3c_ccc_pkg::*;

  ccc_code_e  code;
  logic       load;
  logic       advance;
  logic [7:0] byte_data;
  logic       last;
  logic       supported;

  modport ctrl (output code, load, advance, input byte_data, last, supported);
  modport seq (input code, load, advance, output byte_data, last, supported);

endinterface

`default_nettype wire

// ==== ccc_set_regs.sv ====
// CCC setter block turning received payload bytes into CSR write strobes and values
`default_nettype none

module ccc_set_regs (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  ccc_wr_if.sink                        wr,
  output logic                          enec_ibi_o,
  output logic                          enec_crr_o,
  output logic                          enec_hj_o,
  output logic                          disec_ibi_o,
  output logic                          disec_crr_o,
  output logic                          disec_hj_o,
  output logic                          rstdaa_o,
  output logic                          set_mwl_o,
  output logic [15:0]                   mwl_o,
  output logic                          set_mrl_o,
  output logic [15:0]                   mrl_o,
  output logic                          set_newda_o,
  output logic [i3c_ccc_pkg::AddrW-1:0] newda_o
);
  import i3c_ccc_pkg::*;

  logic first_byte;
  logic second_byte;

  assign first_byte  = wr.byte_strobe && (wr.byte_idx == 3'd0);
  assign second_byte = wr.byte_strobe && (wr.byte_idx == 3'd1);

  // Strobes last one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enec_ibi_o  <= 1'b0;
      enec_crr_o  <= 1'b0;
      enec_hj_o   <= 1'b0;
      disec_ibi_o <= 1'b0;
      disec_crr_o <= 1'b0;
      disec_hj_o  <= 1'b0;
      rstdaa_o    <= 1'b0;
      set_mwl_o   <= 1'b0;
      set_mrl_o   <= 1'b0;
      set_newda_o <= 1'b0;
    end else begin
      enec_ibi_o  <= first_byte && (wr.code inside {CccBcastEnec, CccDirEnec}) && wr.byte_data[0];
      enec_crr_o  <= first_byte && (wr.code inside {CccBcastEnec, CccDirEnec}) && wr.byte_data[1];
      enec_hj_o   <= first_byte && (wr.code inside {CccBcastEnec, CccDirEnec}) && wr.byte_data[3];
      disec_ibi_o <= first_byte && (wr.code inside {CccBcastDisec, CccDirDisec}) &&
                     wr.byte_data[0];
      disec_crr_o <= first_byte && (wr.code inside {CccBcastDisec, CccDirDisec}) &&
                     wr.byte_data[1];
      disec_hj_o  <= first_byte && (wr.code inside {CccBcastDisec, CccDirDisec}) &&
                     wr.byte_data[3];
      rstdaa_o    <= wr.no_data_strobe && (wr.code == CccBcastRstdaa);
      // Length registers update on their low byte
      set_mwl_o   <= second_byte && (wr.code inside {CccBcastSetmwl, CccDirSetmwl});
      set_mrl_o   <= second_byte && (wr.code inside {CccBcastSetmrl, CccDirSetmrl});
      set_newda_o <= first_byte && (wr.code == CccDirSetnewda);
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr.byte_strobe) begin
      case (wr.code)
        CccBcastSetmwl, CccDirSetmwl: begin
          if (wr.byte_idx == 3'd0) mwl_o[15:8] <= wr.byte_data;
          else if (wr.byte_idx == 3'd1) mwl_o[7:0] <= wr.byte_data;
        end
        CccBcastSetmrl, CccDirSetmrl: begin
          if (wr.byte_idx == 3'd0) mrl_o[15:8] <= wr.byte_data;
          else if (wr.byte_idx == 3'd1) mrl_o[7:0] <= wr.byte_data;
        end
        // New address sits above the RnW position
        CccDirSetnewda: begin
          if (wr.byte_idx == 3'd0) newda_o <= wr.byte_data[7:1];
        end
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== ccc_target.f ====
i3c_ccc_pkg.sv
ccc_ctrl_pkg.sv
ccc_wr_if.sv
ccc_rd_if.sv
ccc_fsm.sv
ccc_get_seq.sv
ccc_set_regs.sv
ccc_target.sv
ccc_target_checker.sv
tb_ccc_target.sv

// ==== ccc_target.sv ====
// I3C target CCC handler top level joining the FSM, setter block and GET sequencer
`default_nettype none

module ccc_target #(
  parameter logic [7:0] IbiMaxPayload = 8'hFF
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  i3c_ccc_pkg::ccc_code_e        ccc_i,
  input  logic                          ccc_valid_i,
  input  logic                          bus_rstart_det_i,
  input  logic                          bus_stop_det_i,
  input  logic [7:0]                    bus_rx_data_i,
  input  logic                          bus_rx_done_i,
  input  logic                          bus_tx_done_i,
  input  logic [i3c_ccc_pkg::AddrW-1:0] target_dyn_address_i,
  input  logic                          target_dyn_address_valid_i,
  output logic                          bus_rx_req_bit_o,
  output logic                          bus_rx_req_byte_o,
  output logic                          bus_tx_req_bit_o,
  output logic                          bus_tx_req_byte_o,
  output logic [7:0]                    bus_tx_req_value_o,
  output logic                          bus_tx_sel_od_pp_o,
  output logic                          done_fsm_o,
  output logic                          next_ccc_o,
  output logic                          enec_ibi_o,
  output logic                          enec_crr_o,
  output logic                          enec_hj_o,
  output logic                          disec_ibi_o,
  output logic                          disec_crr_o,
  output logic                          disec_hj_o,
  output logic                          rstdaa_o,
  output logic                          set_mwl_o,
  output logic [15:0]                   mwl_o,
  output logic                          set_mrl_o,
  output logic [15:0]                   mrl_o,
  output logic                          set_newda_o,
  output logic [i3c_ccc_pkg::AddrW-1:0] newda_o,
  input  logic [7:0]                    get_bcr_i,
  input  logic [7:0]                    get_dcr_i,
  input  logic [15:0]                   get_mwl_i,
  input  logic [15:0]                   get_mrl_i,
  input  logic [15:0]                   get_status_i,
  input  logic [i3c_ccc_pkg::PidW-1:0]  get_pid_i
);

  ccc_wr_if wr_if ();
  ccc_rd_if rd_if ();

  ccc_fsm u_fsm (
    .clk_i,
    .rst_ni,
    .ccc_i,
    .ccc_valid_i,
    .bus_rstart_det_i,
    .bus_stop_det_i,
    .bus_rx_data_i,
    .bus_rx_done_i,
    .bus_tx_done_i,
    .target_dyn_address_i,
    .target_dyn_address_valid_i,
    .bus_rx_req_bit_o,
    .bus_rx_req_byte_o,
    .bus_tx_req_bit_o,
    .bus_tx_req_byte_o,
    .bus_tx_req_value_o,
    .bus_tx_sel_od_pp_o,
    .done_fsm_o,
    .next_ccc_o,
    .wr (wr_if.wr),
    .rd (rd_if.ctrl)
  );

  ccc_get_seq #(
    .IbiMaxPayload (IbiMaxPayload)
  ) u_get_seq (
    .clk_i,
    .rst_ni,
    .get_bcr_i,
    .get_dcr_i,
    .get_mwl_i,
    .get_mrl_i,
    .get_status_i,
    .get_pid_i,
    .rd (rd_if.seq)
  );

  ccc_set_regs u_set_regs (
    .clk_i,
    .rst_ni,
    .wr (wr_if.sink),
    .enec_ibi_o,
    .enec_crr_o,
    .enec_hj_o,
    .disec_ibi_o,
    .disec_crr_o,
    .disec_hj_o,
    .rstdaa_o,
    .set_mwl_o,
    .mwl_o,
    .set_mrl_o,
    .mrl_o,
    .set_newda_o,
    .newda_o
  );

endmodule

`default_nettype wire

// ==== ccc_target_checker.sv ====
// Bus request protocol assertions for the CCC transfer sequencer
`default_nettype none

module ccc_target_checker (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     bus_stop_det_i,
  input logic                     bus_rstart_det_i,
  input logic                     bus_rx_done_i,
  input logic                     bus_tx_done_i,
  input logic                     rx_req_bit_i,
  input logic                     rx_req_byte_i,
  input logic                     tx_req_bit_i,
  input logic                     tx_req_byte_i,
  input logic                     done_fsm_i,
  input ccc_ctrl_pkg::ccc_state_e state_i
);
  import ccc_ctrl_pkg::*;

  int unsigned fail_cnt = 0;
  logic [3:0]  reqs;
  logic [3:0]  held;

  assign reqs = {rx_req_bit_i, rx_req_byte_i, tx_req_bit_i, tx_req_byte_i};
  // Requests still waiting for their done
  assign held = {rx_req_bit_i & ~bus_rx_done_i, rx_req_byte_i & ~bus_rx_done_i,
                 tx_req_bit_i & ~bus_tx_done_i, tx_req_byte_i & ~bus_tx_done_i};

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !((rx_req_bit_i || tx_req_bit_i) && (rx_req_byte_i || tx_req_byte_i)))
  else begin
    fail_cnt++;
    $error("Byte and bit request raised together");
  end

  // Only STOP or a repeated START may cut a request short
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (held != 4'b0000) && !bus_stop_det_i && !bus_rstart_det_i |=>
      (reqs & $past(held)) == $past(held))
  else begin
    fail_cnt++;
    $error("Request dropped before its done");
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_stop_det_i |=> done_fsm_i ##1 (state_i == WaitCcc))
  else begin
    fail_cnt++;
    $error("No done pulse and return to WaitCcc after STOP");
  end

endmodule

`default_nettype wire

// ==== ccc_wr_if.sv ====
// CCC write path carrying received payload bytes from the FSM to the setter block
`default_nettype none

interface ccc_wr_if;
  import i3c_ccc_pkg::*;

  ccc_code_e  code;
  logic [7:0] byte_data;
  // Frame position of byte_data saturating at 7
  logic [2:0] byte_idx;
  logic       byte_strobe;
  // T-bit done right after a broadcast code
  logic       no_data_strobe;

  modport wr (output code, byte_data, byte_idx, byte_strobe, no_data_strobe);
  modport sink (input code, byte_data, byte_idx, byte_strobe, no_data_strobe);

endinterface

`default_nettype wire

// ==== i3c_ccc_pkg.sv ====
// I3C CCC protocol package with command codes, address widths and supported-code rules
`default_nettype none

package i3c_ccc_pkg;

  parameter int unsigned AddrW = 7;
  parameter int unsigned PidW = 48;
  parameter logic [AddrW-1:0] RsvdAddr = 7'h7E;

  // Bit 7 set marks a direct code
  typedef enum logic [7:0] {
    CccBcastEnec    = 8'h00,
    CccBcastDisec   = 8'h01,
    CccBcastRstdaa  = 8'h06,
    CccBcastSetmwl  = 8'h09,
    CccBcastSetmrl  = 8'h0A,
    CccDirEnec      = 8'h80,
    CccDirDisec     = 8'h81,
    CccDirSetnewda  = 8'h88,
    CccDirSetmwl    = 8'h89,
    CccDirSetmrl    = 8'h8A,
    CccDirGetmwl    = 8'h8B,
    CccDirGetmrl    = 8'h8C,
    CccDirGetpid    = 8'h8D,
    CccDirGetbcr    = 8'h8E,
    CccDirGetdcr    = 8'h8F,
    CccDirGetstatus = 8'h90
  } ccc_code_e;

  function automatic logic is_direct_code(ccc_code_e code);
    return code[7];
  endfunction

  function automatic logic direct_code_supported(ccc_code_e code);
    return code inside {CccDirEnec, CccDirDisec, CccDirSetnewda, CccDirSetmwl, CccDirSetmrl,
                        CccDirGetmwl, CccDirGetmrl, CccDirGetpid, CccDirGetbcr, CccDirGetdcr,
                        CccDirGetstatus};
  endfunction

endpackage

`default_nettype wire

// ==== tb_ccc_target.sv ====
// Testbench for the CCC target with a bus PHY model, LFSR stimulus and a reference model
`default_nettype none

module tb_ccc_target;
  import i3c_ccc_pkg::*;

  localparam int Frames = 200;
  localparam int CyclesPerFrame = 400;
  localparam int ClkPeriod = 20;
  localparam int Skew = 2;
  localparam int ReqTimeout = 16;
  localparam logic [7:0] IbiMax = 8'h45;
  localparam int KindRxBit = 0;
  localparam int KindRxByte = 1;
  localparam int KindTxBit = 2;
  localparam int KindTxByte = 3;
  // Bit positions follow the pulses vector below
  localparam logic [11:0] PulseDone = 12'h800;
  localparam logic [11:0] PulseNext = 12'h400;
  localparam logic [11:0] PulseRstdaa = 12'h008;
  localparam logic [11:0] PulseMwl = 12'h004;
  localparam logic [11:0] PulseMrl = 12'h002;
  localparam logic [11:0] PulseNewda = 12'h001;

  logic clk_i, rst_ni;
  ccc_code_e ccc_i;
  logic ccc_valid_i, bus_rstart_det_i, bus_stop_det_i;
  logic [7:0] bus_rx_data_i;
  logic bus_rx_done_i, bus_tx_done_i;
  logic [AddrW-1:0] target_dyn_address_i;
  logic target_dyn_address_valid_i;
  logic bus_rx_req_bit_o, bus_rx_req_byte_o, bus_tx_req_bit_o, bus_tx_req_byte_o;
  logic [7:0] bus_tx_req_value_o;
  logic bus_tx_sel_od_pp_o, done_fsm_o, next_ccc_o;
  logic enec_ibi_o, enec_crr_o, enec_hj_o, disec_ibi_o, disec_crr_o, disec_hj_o;
  logic rstdaa_o, set_mwl_o, set_mrl_o, set_newda_o;
  logic [15:0] mwl_o, mrl_o;
  logic [AddrW-1:0] newda_o;
  logic [7:0] get_bcr_i, get_dcr_i;
  logic [15:0] get_mwl_i, get_mrl_i, get_status_i;
  logic [PidW-1:0] get_pid_i;

  logic [11:0] pulses;
  logic [11:0] exp_pulse;
  logic [31:0] lfsr;
  logic [7:0] resp_q [$];
  int errors;
  int checks;

  string pulse_names [0:11] = '{"set_newda_o", "set_mrl_o", "set_mwl_o", "rstdaa_o",
                                "disec_hj_o", "disec_crr_o", "disec_ibi_o", "enec_hj_o",
                                "enec_crr_o", "enec_ibi_o", "next_ccc_o", "done_fsm_o"};
  string kind_names [0:3] = '{"RX bit", "RX byte", "TX bit", "TX byte"};
  // Five broadcast codes followed by the kept direct codes
  ccc_code_e code_tab [0:15] = '{CccBcastEnec, CccBcastDisec, CccBcastRstdaa, CccBcastSetmwl,
                                 CccBcastSetmrl, CccDirEnec, CccDirDisec, CccDirSetnewda,
                                 CccDirSetmwl, CccDirSetmrl, CccDirGetmwl, CccDirGetmrl,
                                 CccDirGetpid, CccDirGetbcr, CccDirGetdcr, CccDirGetstatus};

  assign pulses = {done_fsm_o, next_ccc_o, enec_ibi_o, enec_crr_o, enec_hj_o, disec_ibi_o,
                   disec_crr_o, disec_hj_o, rstdaa_o, set_mwl_o, set_mrl_o, set_newda_o};

  ccc_target #(
    .IbiMaxPayload (IbiMax)
  ) dut (.*);

  bind ccc_fsm ccc_target_checker u_checker (
    .clk_i,
    .rst_ni,
    .bus_stop_det_i,
    .bus_rstart_det_i,
    .bus_rx_done_i,
    .bus_tx_done_i,
    .rx_req_bit_i  (bus_rx_req_bit_o),
    .rx_req_byte_i (bus_rx_req_byte_o),
    .tx_req_bit_i  (bus_tx_req_bit_o),
    .tx_req_byte_i (bus_tx_req_byte_o),
    .done_fsm_i    (done_fsm_o),
    .state_i       (state_q)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin
    #(Frames * CyclesPerFrame * ClkPeriod);
    $display("Timeout after %0d cycles, the frames did not complete", Frames * CyclesPerFrame);
    $display("Regression failed");
    $finish;
  end

  // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic fb;
    int i;
    r = '0;
    for (i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic req_of(input int kind);
    case (kind)
      KindRxBit:  return bus_rx_req_bit_o;
      KindRxByte: return bus_rx_req_byte_o;
      KindTxBit:  return bus_tx_req_bit_o;
      default:    return bus_tx_req_byte_o;
    endcase
  endfunction

  function automatic int payload_len(input ccc_code_e code);
    if (code inside {CccBcastSetmwl, CccBcastSetmrl, CccDirSetmwl, CccDirSetmrl}) return 2;
    if (code inside {CccBcastEnec, CccBcastDisec, CccDirEnec, CccDirDisec, CccDirSetnewda})
      return 1;
    return 0;
  endfunction

  // Strobes expected one cycle after the T-bit of payload byte idx
  function automatic logic [11:0] byte_pulses(input ccc_code_e code, input int idx,
                                              input logic [7:0] d);
    logic [2:0] ev;
    ev = {d[0], d[1], d[3]};
    case (code)
      CccBcastEnec, CccDirEnec:     return (idx == 0) ? {2'b00, ev, 7'h00} : 12'h000;
      CccBcastDisec, CccDirDisec:   return (idx == 0) ? {5'h00, ev, 4'h0} : 12'h000;
      CccBcastSetmwl, CccDirSetmwl: return (idx == 1) ? PulseMwl : 12'h000;
      CccBcastSetmrl, CccDirSetmrl: return (idx == 1) ? PulseMrl : 12'h000;
      CccDirSetnewda:               return (idx == 0) ? PulseNewda : 12'h000;
      default:                      return 12'h000;
    endcase
  endfunction

  task automatic compare(input string name, input logic [47:0] got, input logic [47:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERR t=%0t %s exp=%0h got=%0h", $time, name, exp, got);
    end
  endtask

  // One clock step with the pulse outputs checked
  task automatic tick();
    int i;
    @(posedge clk_i);
    #(Skew);
    for (i = 0; i < 12; i++) compare(pulse_names[i], pulses[i], exp_pulse[i]);
    exp_pulse = '0;
  endtask

  // PHY model answering one request after 1 to 4 cycles
  task automatic answer(input int kind, input logic [7:0] value, input logic sel,
                        input logic [11:0] after);
    int waited;
    waited = 0;
    while (req_of(kind) !== 1'b1 && waited < ReqTimeout) begin
      tick();
      waited++;
    end
    assert (waited < ReqTimeout) else begin
      errors++;
      $display("No %s request from the DUT within %0d cycles", kind_names[kind], ReqTimeout);
    end
    repeat (rand_bits(2)) tick();
    if (kind >= KindTxBit) begin
      compare("bus_tx_req_value_o", bus_tx_req_value_o, value);
      compare("bus_tx_sel_od_pp_o", bus_tx_sel_od_pp_o, sel);
      bus_tx_done_i = 1'b1;
    end else begin
      bus_rx_data_i = value;
      bus_rx_done_i = 1'b1;
    end
    exp_pulse = after;
    tick();
    bus_rx_done_i = 1'b0;
    bus_tx_done_i = 1'b0;
    bus_rx_data_i = 8'(rand_bits(8));
  endtask

  task automatic start_ccc(input ccc_code_e code);
    ccc_i = code;
    ccc_valid_i = 1'b1;
    tick();
    ccc_valid_i = 1'b0;
    compare("bus_rx_req_bit_o", bus_rx_req_bit_o, 1'b1);
  endtask

  task automatic issue_restart();
    compare("bus_rx_req_byte_o", bus_rx_req_byte_o, 1'b1);
    repeat (rand_bits(2)) tick();
    bus_rstart_det_i = 1'b1;
    tick();
    bus_rstart_det_i = 1'b0;
  endtask

  task automatic end_with_stop();
    repeat (rand_bits(2)) tick();
    bus_stop_det_i = 1'b1;
    exp_pulse = PulseDone;
    tick();
    bus_stop_det_i = 1'b0;
    tick();
  endtask

  task automatic send_payload(input ccc_code_e code);
    logic [7:0] b [0:1];
    int i;
    b[0] = 8'h00;
    b[1] = 8'h00;
    for (i = 0; i < payload_len(code); i++) begin
      b[i] = 8'(rand_bits(8));
      answer(KindRxByte, b[i], 1'b0, 12'h000);
      answer(KindRxBit, 8'(rand_bits(1)), 1'b0, byte_pulses(code, i, b[i]));
    end
    if (code inside {CccBcastSetmwl, CccDirSetmwl}) compare("mwl_o", mwl_o, {b[0], b[1]});
    if (code inside {CccBcastSetmrl, CccDirSetmrl}) compare("mrl_o", mrl_o, {b[0], b[1]});
    if (code == CccDirSetnewda) compare("newda_o", newda_o, b[0][7:1]);
  endtask

  // Expected GET reply built from the CSR inputs with the most significant byte first
  task automatic build_response(input ccc_code_e code);
    int i;
    resp_q.delete();
    case (code)
      CccDirGetbcr: resp_q.push_back(get_bcr_i);
      CccDirGetdcr: resp_q.push_back(get_dcr_i);
      CccDirGetmwl: resp_q = '{get_mwl_i[15:8], get_mwl_i[7:0]};
      CccDirGetstatus: resp_q = '{get_status_i[15:8], get_status_i[7:0]};
      CccDirGetmrl: resp_q = '{get_mrl_i[15:8], get_mrl_i[7:0], IbiMax};
      CccDirGetpid: begin
        for (i = 5; i >= 0; i--) resp_q.push_back(get_pid_i[8*i +: 8]);
      end
      default: resp_q.delete();
    endcase
  endtask

  task automatic run_broadcast(input ccc_code_e code);
    start_ccc(code);
    answer(KindRxBit, 8'(rand_bits(1)), 1'b0, (code == CccBcastRstdaa) ? PulseRstdaa : 12'h000);
    send_payload(code);
    end_with_stop();
  endtask

  task automatic run_direct(input ccc_code_e code, input logic kept);
    logic [AddrW-1:0] addr;
    logic rnw;
    logic is_get;
    logic ack;
    int pick;
    int i;
    is_get = code inside {CccDirGetmwl, CccDirGetmrl, CccDirGetpid, CccDirGetbcr, CccDirGetdcr,
                          CccDirGetstatus};
    rnw = kept ? is_get : 1'(rand_bits(1));
    pick = rand_bits(3);
    if (pick == 0) begin
      addr = RsvdAddr;
    end else if (pick == 1) begin
      // Upper half of the space never holds our address
      addr = {1'b1, 6'(rand_bits(6))};
      if (addr == RsvdAddr) addr = 7'h7D;
    end else begin
      addr = target_dyn_address_i;
    end
    ack = (addr == RsvdAddr) || (target_dyn_address_valid_i && addr == target_dyn_address_i &&
                                 (rnw ? is_get : kept));
    start_ccc(code);
    answer(KindRxBit, 8'(rand_bits(1)), 1'b0, 12'h000);
    issue_restart();
    answer(KindRxByte, {addr, rnw}, 1'b0, 12'h000);
    answer(KindTxBit, {7'h00, ~ack}, 1'b0, (addr == RsvdAddr) ? PulseNext : 12'h000);
    if (ack && addr != RsvdAddr) begin
      if (rnw) begin
        build_response(code);
        for (i = 0; i < resp_q.size(); i++) begin
          answer(KindTxByte, resp_q[i], 1'b1, 12'h000);
          answer(KindTxBit, {7'h00, i != resp_q.size() - 1}, 1'b1, 12'h000);
        end
      end else begin
        send_payload(code);
      end
    end
    end_with_stop();
  endtask

  initial begin
    int f;
    int i;
    int sel;
    int asrt_fails;
    lfsr = 32'hb893;
    errors = 0;
    checks = 0;
    exp_pulse = '0;
    rst_ni = 1'b0;
    ccc_i = CccBcastEnec;
    ccc_valid_i = 1'b0;
    bus_rstart_det_i = 1'b0;
    bus_stop_det_i = 1'b0;
    bus_rx_data_i = 8'h00;
    bus_rx_done_i = 1'b0;
    bus_tx_done_i = 1'b0;
    target_dyn_address_i = 7'h21;
    target_dyn_address_valid_i = 1'b1;
    get_bcr_i = 8'h00;
    get_dcr_i = 8'h00;
    get_mwl_i = 16'h0000;
    get_mrl_i = 16'h0000;
    get_status_i = 16'h0000;
    get_pid_i = '0;
    repeat (10) @(posedge clk_i);
    #(Skew);
    rst_ni = 1'b1;
    compare("bus_rx_req_bit_o", bus_rx_req_bit_o, 1'b0);
    compare("bus_rx_req_byte_o", bus_rx_req_byte_o, 1'b0);
    compare("bus_tx_req_bit_o", bus_tx_req_bit_o, 1'b0);
    compare("bus_tx_req_byte_o", bus_tx_req_byte_o, 1'b0);
    for (i = 0; i < 12; i++) compare(pulse_names[i], pulses[i], 1'b0);
    for (f = 0; f < Frames; f++) begin
      get_bcr_i = 8'(rand_bits(8));
      get_dcr_i = 8'(rand_bits(8));
      get_mwl_i = 16'(rand_bits(16));
      get_mrl_i = 16'(rand_bits(16));
      get_status_i = 16'(rand_bits(16));
      get_pid_i = {16'(rand_bits(16)), rand_bits(32)};
      target_dyn_address_i = {1'b0, 6'(rand_bits(6))};
      target_dyn_address_valid_i = (rand_bits(4) != 0);
      tick();
      sel = rand_bits(4);
      if (sel < 5) run_broadcast(code_tab[sel]);
      else if (rand_bits(4) == 0) run_direct(ccc_code_e'(8'hA3), 1'b0);
      else run_direct(code_tab[sel], 1'b1);
    end
    repeat (4) tick();
    asrt_fails = dut.u_fsm.u_checker.fail_cnt;
    $display("Checks run: %0d, check errors: %0d, assertion failures: %0d",
             checks, errors, asrt_fails);
    if (errors == 0 && asrt_fails == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
